/* bench/tb_checker.sv */
module tb_checker (
  input  logic                          clk,
  input  logic                          rstn,
  input  riscv_wb_pkg::ex_stage_t       ex,
  input  riscv_wb_pkg::wb_stage_t       wb,
  input  logic [4:0]                    radr,
  input  logic [riscv_wb_pkg::XLEN-1:0] rdata,
  input  logic                          done,
  output logic                          reported,
  output int                            errors
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NTESTS = 5;

  // Model memory and register file
  logic [31:0]             mem_m [riscv_wb_pkg::DMEM_WORDS];
  logic [31:0]             regs_m [32];
  int                      chk_n [NTESTS];
  int                      err_n [NTESTS];

  // Record latched on the last edge and what it should produce
  riscv_wb_pkg::ex_stage_t rec_q;
  logic                    rec_v;
  logic                    seen_edge;
  logic [11:0]             exp_exc;
  logic [31:0]             exp_bad;

  // Register write due on the next edge
  logic                    pend_we;
  logic                    pend_ld;
  logic [4:0]              pend_dst;
  logic [31:0]             pend_data;
  // Write that landed on the last edge
  logic                    last_ld;
  logic [4:0]              last_dst;

  ////////////////////////////////////////////////////////////////////////////
  // Model rules
  ////////////////////////////////////////////////////////////////////////////

  // func3[1:0] is log2 of the access size
  function automatic logic misaligned(input logic [2:0] f3, input logic [1:0] lo);
    case (f3[1:0])
      2'd0:    return 1'b0;
      2'd1:    return lo[0];
      default: return |lo;
    endcase
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] w, input logic [2:0] f3,
                                             input logic [1:0] lo);
    logic [31:0] sh;
    sh = w >> (8 * lo);
    case (f3)
      riscv_wb_pkg::LB:  return {{24{sh[7]}}, sh[7:0]};
      riscv_wb_pkg::LBU: return {24'd0, sh[7:0]};
      riscv_wb_pkg::LH:  return {{16{sh[15]}}, sh[15:0]};
      riscv_wb_pkg::LHU: return {16'd0, sh[15:0]};
      default:           return w;
    endcase
  endfunction

  // Low bytes of r go to lanes lo and up
  task automatic store_model(input logic [7:0] idx, input logic [2:0] f3, input logic [1:0] lo,
                             input logic [31:0] r);
    int nbytes;
    nbytes = 1 << f3[1:0];
    for (int b = 0; b < nbytes; b++) begin
      mem_m[idx][8 * (int'(lo) + b) +: 8] = r[8 * b +: 8];
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset values";
      1:       return "write-back pass-through";
      2:       return "bad address";
      3:       return "loads and stores";
      default: return "register writes";
    endcase
  endfunction

  task automatic check_value(input int t, input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_n[t] = chk_n[t] + 1;
    if (got !== exp) begin
      err_n[t] = err_n[t] + 1;
      $display("Error %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic print_line(input int t);
    if (chk_n[t] == 0) begin
      err_n[t] = 1;
      $display("%s: no checks ran", test_name(t));
    end else begin
      $display("%s: %0d checks, %0d errors", test_name(t), chk_n[t], err_n[t]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model update on the clock edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : capture
    logic [4:0] opc;
    logic [2:0] f3;
    logic [1:0] lo;
    logic [7:0] idx;
    logic       is_ld;
    logic       is_st;
    logic       mis;
    logic       mem_cause;
    seen_edge = 1'b1;
    if (!rstn) begin
      rec_v   = 1'b0;
      pend_we = 1'b0;
      pend_ld = 1'b0;
      last_ld = 1'b0;
      for (int i = 0; i < 32; i++) begin
        regs_m[i] = '0;
      end
    end else begin
      // First record ends the reset test
      if (!rec_v) begin
        print_line(0);
      end
      // Write of the record before lands here
      last_ld  = pend_we & pend_ld;
      last_dst = pend_dst;
      if (pend_we) begin
        regs_m[pend_dst] = pend_data;
      end
      opc   = ex.instr[6:2];
      f3    = ex.instr[14:12];
      lo    = ex.memadr[1:0];
      idx   = ex.memadr[9:2];
      is_ld = !ex.bubble && (opc == riscv_wb_pkg::OPC_LOAD);
      is_st = !ex.bubble && (opc == riscv_wb_pkg::OPC_STORE);
      mis   = misaligned(f3, lo);
      exp_exc = ex.exception;
      if (is_ld && mis) exp_exc[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD] = 1'b1;
      if (is_st && mis) exp_exc[riscv_wb_pkg::CAUSE_MISALIGNED_STORE] = 1'b1;
      mem_cause = exp_exc[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD] |
                  exp_exc[riscv_wb_pkg::CAUSE_MISALIGNED_STORE] |
                  exp_exc[riscv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT] |
                  exp_exc[riscv_wb_pkg::CAUSE_STORE_ACCESS_FAULT];
      exp_bad = mem_cause ? ex.memadr : ex.pc;
      // Load reads memory as it stands before this edge's own store
      pend_ld   = is_ld;
      pend_dst  = ex.instr[11:7];
      pend_data = is_ld ? load_value(mem_m[idx], f3, lo) : ex.r;
      pend_we   = !ex.bubble && (exp_exc == '0) && (pend_dst != 5'd0) &&
                  !(opc inside {riscv_wb_pkg::OPC_STORE, riscv_wb_pkg::OPC_BRANCH,
                                riscv_wb_pkg::OPC_MISC_MEM});
      if (is_st && (ex.exception == '0) && !mis) begin
        store_model(idx, f3, lo, ex.r);
      end
      rec_q = ex;
      rec_v = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparisons mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rec_v) begin
      if (seen_edge) begin
        check_value(0, "reset wb.pc", wb.pc, riscv_wb_pkg::PC_INIT);
        check_value(0, "reset wb.instr", wb.instr, riscv_wb_pkg::INSTR_NOP);
        check_value(0, "reset wb.bubble", {31'd0, wb.bubble}, 32'd1);
        check_value(0, "reset wb.exception", {20'd0, wb.exception}, 32'd0);
        check_value(0, "reset rdata", rdata, 32'd0);
      end
    end else if (!done) begin
      check_value(1, "wb.pc", wb.pc, rec_q.pc);
      check_value(1, "wb.instr", wb.instr, rec_q.instr);
      check_value(1, "wb.bubble", {31'd0, wb.bubble}, {31'd0, rec_q.bubble});
      check_value(1, "wb.exception", {20'd0, wb.exception}, {20'd0, exp_exc});
      check_value(2, "wb.badaddr", wb.badaddr, exp_bad);
      // Register just loaded counts as a load check
      check_value((last_ld && radr == last_dst) ? 3 : 4, $sformatf("rdata of x%0d", radr),
                  rdata, regs_m[radr]);
    end
  end

  initial begin
    reported  = 1'b0;
    errors    = 0;
    rec_v     = 1'b0;
    seen_edge = 1'b0;
    for (int t = 0; t < NTESTS; t++) begin
      chk_n[t] = 0;
      err_n[t] = 0;
    end
    for (int i = 0; i < riscv_wb_pkg::DMEM_WORDS; i++) begin
      mem_m[i] = '0;
    end
    wait (done === 1'b1);
    for (int t = 1; t < NTESTS; t++) begin
      print_line(t);
    end
    for (int t = 0; t < NTESTS; t++) begin
      errors = errors + err_n[t];
    end
    $display("Total: %0d checks, %0d errors",
             chk_n[0] + chk_n[1] + chk_n[2] + chk_n[3] + chk_n[4], errors);
    reported = 1'b1;
  end

endmodule

/* bench/tb_top.sv */
module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int N_RST      = 16;
  localparam int N_REC      = 3000;
  // The first records fill every memory word
  localparam int N_INIT     = riscv_wb_pkg::DMEM_WORDS;
  localparam int N_SWEEP    = 64;
  localparam int TIMEOUT_NS = (N_REC + N_SWEEP + N_RST) * CLK_PERIOD * 2;

  logic                          clk;
  logic                          rstn;
  riscv_wb_pkg::ex_stage_t       ex;
  riscv_wb_pkg::wb_stage_t       wb;
  logic [4:0]                    radr;
  logic [riscv_wb_pkg::XLEN-1:0] rdata;

  logic                          done;
  logic                          reported;
  int                            errors;

  // Generator state
  logic [31:0]                   rng;
  // {is_load, dst} of the last two records
  logic [5:0]                    ld_q1;
  logic [5:0]                    ld_q2;

  riscv_mem_top uut (
    .clk   (clk),
    .rstn  (rstn),
    .ex    (ex),
    .wb    (wb),
    .radr  (radr),
    .rdata (rdata)
  );

  tb_checker chk (
    .clk      (clk),
    .rstn     (rstn),
    .ex       (ex),
    .wb       (wb),
    .radr     (radr),
    .rdata    (rdata),
    .done     (done),
    .reported (reported),
    .errors   (errors)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random records
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng = xorshift(rng);
    v   = rng;
  endtask

  task automatic make_record(input int idx, output riscv_wb_pkg::ex_stage_t rec);
    logic [31:0] adr;
    logic [31:0] ctl;
    logic [31:0] pc;
    logic [31:0] data;
    logic [31:0] hi;
    logic [4:0]  opc;
    logic [2:0]  f3;
    draw(adr);
    draw(ctl);
    draw(pc);
    draw(data);
    draw(hi);
    rec        = '0;
    rec.pc     = pc;
    rec.r      = data;
    rec.memadr = adr;
    if (idx < N_INIT) begin
      // Word store to word idx, upper address bits ignored by the memory
      opc        = riscv_wb_pkg::OPC_STORE;
      f3         = riscv_wb_pkg::SW;
      rec.memadr = {adr[31:10], idx[7:0], 2'b00};
    end else begin
      case (ctl[2:0])
        3'd0, 3'd1, 3'd2: opc = riscv_wb_pkg::OPC_LOAD;
        3'd3, 3'd4:       opc = riscv_wb_pkg::OPC_STORE;
        3'd5:             opc = riscv_wb_pkg::OPC_OP;
        3'd6:             opc = riscv_wb_pkg::OPC_OP_IMM;
        default:          opc = ctl[3] ? riscv_wb_pkg::OPC_BRANCH : riscv_wb_pkg::OPC_MISC_MEM;
      endcase
      f3 = hi[14:12];
      if (opc == riscv_wb_pkg::OPC_LOAD) begin
        case (ctl[7:4] % 4'd5)
          4'd0:    f3 = riscv_wb_pkg::LB;
          4'd1:    f3 = riscv_wb_pkg::LH;
          4'd2:    f3 = riscv_wb_pkg::LW;
          4'd3:    f3 = riscv_wb_pkg::LBU;
          default: f3 = riscv_wb_pkg::LHU;
        endcase
      end else if (opc == riscv_wb_pkg::OPC_STORE) begin
        case (ctl[7:4] % 4'd3)
          4'd0:    f3 = riscv_wb_pkg::SB;
          4'd1:    f3 = riscv_wb_pkg::SH;
          default: f3 = riscv_wb_pkg::SW;
        endcase
      end
      // Half the addresses aligned for every width
      if (ctl[19]) begin
        rec.memadr[1:0] = 2'b00;
      end
      rec.bubble = (ctl[10:8] == 3'd0);
      // Rare incoming exception, one random cause
      if (ctl[14:11] == 4'd0) begin
        rec.exception[ctl[18:15] % 4'd12] = 1'b1;
      end
    end
    rec.instr = {hi[31:15], f3, ctl[24:20], opc, 2'b11};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    riscv_wb_pkg::ex_stage_t rec;
    logic [31:0]             v;
    clk      = 1'b0;
    rstn     = 1'b0;
    ex       = '0;
    ex.bubble = 1'b1;
    ex.instr = riscv_wb_pkg::INSTR_NOP;
    radr     = 5'd31;
    done     = 1'b0;
    rng      = 32'd59846;
    ld_q1    = '0;
    ld_q2    = '0;
    repeat (N_RST) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < N_REC; i++) begin
      make_record(i, rec);
      draw(v);
      ex <= rec;
      // A load from two records back is in the register file now
      radr <= ld_q2[5] ? ld_q2[4:0] : v[4:0];
      ld_q2 = ld_q1;
      ld_q1 = {~rec.bubble & (rec.instr[6:2] == riscv_wb_pkg::OPC_LOAD), rec.instr[11:7]};
      @(posedge clk);
    end
    // Bubbles while every register is read back
    for (int j = 0; j < N_SWEEP; j++) begin
      make_record(N_INIT, rec);
      rec.bubble = 1'b1;
      ex   <= rec;
      radr <= j[4:0];
      @(posedge clk);
    end
    done <= 1'b1;
    wait (reported === 1'b1);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

/* common/riscv_wb_pkg.sv */
package riscv_wb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Integer data width and instruction width
  localparam int XLEN       = 32;
  localparam int INSTR_SIZE = 32;

  // Data memory depth in words, 10 byte-address bits
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // Reset values of the write-back state
  localparam logic [XLEN-1:0]       PC_INIT   = 32'h0000_0200;
  // addi x0,x0,0
  localparam logic [INSTR_SIZE-1:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and width codes
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes, instr[6:2]
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;

  // Load widths, func3
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;

  // Store widths, func3
  localparam logic [2:0] SB  = 3'b000;
  localparam logic [2:0] SH  = 3'b001;
  localparam logic [2:0] SW  = 3'b010;

  ////////////////////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////////////////////

  localparam int EXC_SIZE = 12;

  // Bit positions follow the mcause codes
  localparam int CAUSE_ILLEGAL            = 2;
  localparam int CAUSE_MISALIGNED_LOAD    = 4;
  localparam int CAUSE_LOAD_ACCESS_FAULT  = 5;
  localparam int CAUSE_MISALIGNED_STORE   = 6;
  localparam int CAUSE_STORE_ACCESS_FAULT = 7;

  ////////////////////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////////////////////

  // Execute-stage record, 141 bits
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [INSTR_SIZE-1:0] instr;
    logic                  bubble;
    logic [EXC_SIZE-1:0]   exception;
    logic [XLEN-1:0]       r;
    logic [XLEN-1:0]       memadr;
  } ex_stage_t;

  // Data memory request, adr is a word index
  typedef struct packed {
    logic                 we;
    logic [XLEN/8-1:0]    be;
    logic [DMEM_AW-1:0]   adr;
    logic [XLEN-1:0]      wdata;
  } dmem_req_t;

  // Registered write-back state
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [INSTR_SIZE-1:0] instr;
    logic                  bubble;
    logic [EXC_SIZE-1:0]   exception;
    logic [XLEN-1:0]       badaddr;
  } wb_stage_t;

  // Register file write port
  typedef struct packed {
    logic            we;
    logic [4:0]      dst;
    logic [XLEN-1:0] data;
  } rf_wr_t;

endpackage

/* design/lsu/riscv_load_align.sv */
module riscv_load_align (
  input  logic [riscv_wb_pkg::XLEN-1:0] rdata,
  input  logic [2:0]                    func3,
  input  logic [1:0]                    adr_lo,
  output logic [riscv_wb_pkg::XLEN-1:0] q
);

  localparam int XLEN = riscv_wb_pkg::XLEN;

  logic [7:0]  qb;
  logic [15:0] qh;

  // Addressed byte of the read word
  assign qb = rdata[{adr_lo, 3'b000} +: 8];

  // Addressed halfword, aligned loads only reach here
  assign qh = adr_lo[1] ? rdata[31:16] : rdata[15:0];

  // Sign or zero extension by the load width
  always_comb begin
    case (func3)
      riscv_wb_pkg::LB:  q = {{(XLEN-8){qb[7]}}, qb};
      riscv_wb_pkg::LBU: q = {{(XLEN-8){1'b0}}, qb};
      riscv_wb_pkg::LH:  q = {{(XLEN-16){qh[15]}}, qh};
      riscv_wb_pkg::LHU: q = {{(XLEN-16){1'b0}}, qh};
      // LW and unknown codes take the whole word
      default:           q = rdata;
    endcase
  end

endmodule

/* design/lsu/riscv_lsu.sv */
module riscv_lsu (
  input  riscv_wb_pkg::ex_stage_t            ex,
  output riscv_wb_pkg::dmem_req_t            req,
  output logic [riscv_wb_pkg::EXC_SIZE-1:0]  exception
);

  logic [4:0] opcode;
  logic [2:0] func3;
  logic [1:0] adr_lo;
  logic       is_load;
  logic       is_store;
  // log2 of the access size in bytes
  logic [1:0] sz;
  logic       misaligned;
  logic       access;
  logic [3:0] lane_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = ex.instr[6:2];
  assign func3  = ex.instr[14:12];
  assign adr_lo = ex.memadr[1:0];

  // Bubbles never count as memory instructions
  assign is_load  = ~ex.bubble & (opcode == riscv_wb_pkg::OPC_LOAD);
  assign is_store = ~ex.bubble & (opcode == riscv_wb_pkg::OPC_STORE);

  // Access size from func3, unknown codes act as a word
  always_comb begin
    if (is_store) begin
      case (func3)
        riscv_wb_pkg::SB: sz = 2'd0;
        riscv_wb_pkg::SH: sz = 2'd1;
        riscv_wb_pkg::SW: sz = 2'd2;
        default:          sz = 2'd2;
      endcase
    end else begin
      case (func3)
        riscv_wb_pkg::LB, riscv_wb_pkg::LBU: sz = 2'd0;
        riscv_wb_pkg::LH, riscv_wb_pkg::LHU: sz = 2'd1;
        riscv_wb_pkg::LW:                    sz = 2'd2;
        default:                             sz = 2'd2;
      endcase
    end
  end

  // Halfwords need an even address, words a multiple of four
  assign misaligned = ((sz == 2'd1) & adr_lo[0]) | ((sz == 2'd2) & (|adr_lo));

  // Byte lanes touched by the access
  always_comb begin
    case (sz)
      2'd0:    lane_mask = 4'b0001 << adr_lo;
      2'd1:    lane_mask = 4'b0011 << adr_lo;
      default: lane_mask = 4'b1111;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and exceptions
  ////////////////////////////////////////////////////////////////////////////

  // Excepted or misaligned instructions never reach the memory
  assign access = (is_load | is_store) & ~(|ex.exception) & ~misaligned;

  assign req.we    = access & is_store;
  assign req.be    = access ? lane_mask : 4'b0000;
  assign req.adr   = ex.memadr[riscv_wb_pkg::DMEM_AW+1:2];
  // Store data moved up into its byte lanes
  assign req.wdata = ex.r << {adr_lo, 3'b000};

  always_comb begin
    exception = ex.exception;
    exception[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD]  = ex.exception[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD] |
                                                      (is_load & misaligned);
    exception[riscv_wb_pkg::CAUSE_MISALIGNED_STORE] = ex.exception[riscv_wb_pkg::CAUSE_MISALIGNED_STORE] |
                                                      (is_store & misaligned);
  end

  // Written lanes stay inside [adr_lo, adr_lo + size) of the addressed word
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (req.we && req.be[i]) begin
        assert (i >= int'(adr_lo) && i < int'(adr_lo) + (1 << sz))
          else $error("lsu: byte enable %0d outside addressed lanes", i);
      end
    end
  end

endmodule

/* design/riscv_dmem.sv */
module riscv_dmem (
  input  logic                          clk,
  input  riscv_wb_pkg::dmem_req_t       req,
  output logic [riscv_wb_pkg::XLEN-1:0] rdata
);

  localparam int XLEN  = riscv_wb_pkg::XLEN;
  localparam int LANES = XLEN / 8;

  // Word array
  logic [XLEN-1:0] mem [riscv_wb_pkg::DMEM_WORDS];

  ////////////////////////////////////////////////////////////////////////////
  // Byte writes
  ////////////////////////////////////////////////////////////////////////////

  // One lane per byte enable
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (req.we && req.be[i]) begin
        mem[req.adr][8*i +: 8] <= req.wdata[8*i +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered read
  ////////////////////////////////////////////////////////////////////////////

  // Data shows one clock after the address
  // A store on the edge before is already in the array
  always_ff @(posedge clk) begin
    rdata <= mem[req.adr];
  end

endmodule

/* design/riscv_mem_top.sv */
module riscv_mem_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  riscv_wb_pkg::ex_stage_t       ex,
  output riscv_wb_pkg::wb_stage_t       wb,
  input  logic [4:0]                    radr,
  output logic [riscv_wb_pkg::XLEN-1:0] rdata
);

  // LSU to memory and write-back
  riscv_wb_pkg::dmem_req_t             dmem_req;
  logic [riscv_wb_pkg::EXC_SIZE-1:0]   lsu_exc;

  // Read path
  logic [riscv_wb_pkg::XLEN-1:0]       dmem_rdata;
  logic [2:0]                          ld_func3;
  logic [1:0]                          ld_adr_lo;
  logic [riscv_wb_pkg::XLEN-1:0]       load_q;

  // Register file write
  riscv_wb_pkg::rf_wr_t                rf_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Memory access
  ////////////////////////////////////////////////////////////////////////////

  riscv_lsu u_lsu (
    .ex        (ex),
    .req       (dmem_req),
    .exception (lsu_exc)
  );

  riscv_dmem u_dmem (
    .clk   (clk),
    .req   (dmem_req),
    .rdata (dmem_rdata)
  );

  // Uses func3 and address bits latched with the read
  riscv_load_align u_load_align (
    .rdata  (dmem_rdata),
    .func3  (ld_func3),
    .adr_lo (ld_adr_lo),
    .q      (load_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Write back
  ////////////////////////////////////////////////////////////////////////////

  riscv_memwb u_memwb (
    .clk       (clk),
    .rstn      (rstn),
    .ex        (ex),
    .exception (lsu_exc),
    .load_q    (load_q),
    .func3     (ld_func3),
    .adr_lo    (ld_adr_lo),
    .wb        (wb),
    .rf_wr     (rf_wr)
  );

  riscv_regfile u_regfile (
    .clk   (clk),
    .rstn  (rstn),
    .rf_wr (rf_wr),
    .radr  (radr),
    .rdata (rdata)
  );

endmodule

/* design/riscv_memwb.sv */
module riscv_memwb (
  input  logic                              clk,
  input  logic                              rstn,
  input  riscv_wb_pkg::ex_stage_t           ex,
  input  logic [riscv_wb_pkg::EXC_SIZE-1:0] exception,
  input  logic [riscv_wb_pkg::XLEN-1:0]     load_q,
  output logic [2:0]                        func3,
  output logic [1:0]                        adr_lo,
  output riscv_wb_pkg::wb_stage_t           wb,
  output riscv_wb_pkg::rf_wr_t              rf_wr
);

  logic [4:0]                    opcode;
  logic [4:0]                    dst;
  logic                          mem_cause;
  logic                          we_d;

  // Registered write-back side
  logic                          we_q;
  logic [4:0]                    dst_q;
  logic [riscv_wb_pkg::XLEN-1:0] r_q;
  logic                          is_load_q;

  assign opcode = ex.instr[6:2];
  assign dst    = ex.instr[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // Any of the four memory causes
  assign mem_cause = exception[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD]   |
                     exception[riscv_wb_pkg::CAUSE_MISALIGNED_STORE]  |
                     exception[riscv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT] |
                     exception[riscv_wb_pkg::CAUSE_STORE_ACCESS_FAULT];

  // Register file write enable
  always_comb begin
    if (ex.bubble || (|exception) || dst == 5'd0) begin
      we_d = 1'b0;
    end else begin
      case (opcode)
        riscv_wb_pkg::OPC_STORE,
        riscv_wb_pkg::OPC_BRANCH,
        riscv_wb_pkg::OPC_MISC_MEM: we_d = 1'b0;
        riscv_wb_pkg::OPC_LOAD,
        riscv_wb_pkg::OPC_OP,
        riscv_wb_pkg::OPC_OP_IMM:   we_d = 1'b1;
        // lui, auipc, jumps and the rest write rd
        default:                    we_d = 1'b1;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb <= '{pc:        riscv_wb_pkg::PC_INIT,
              instr:     riscv_wb_pkg::INSTR_NOP,
              bubble:    1'b1,
              exception: '0,
              badaddr:   '0};
    end else begin
      wb.pc        <= ex.pc;
      wb.instr     <= ex.instr;
      wb.bubble    <= ex.bubble;
      wb.exception <= exception;
      // Faulting data address, else the pc
      wb.badaddr   <= mem_cause ? ex.memadr : ex.pc;
    end
  end

  // Control flops
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      we_q      <= 1'b0;
      is_load_q <= 1'b0;
    end else begin
      we_q      <= we_d;
      is_load_q <= (opcode == riscv_wb_pkg::OPC_LOAD);
    end
  end

  // Payload, latched with the memory read
  always_ff @(posedge clk) begin
    dst_q  <= dst;
    r_q    <= ex.r;
    func3  <= ex.instr[14:12];
    adr_lo <= ex.memadr[1:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  assign rf_wr.we   = we_q;
  assign rf_wr.dst  = dst_q;
  assign rf_wr.data = is_load_q ? load_q : r_q;

  // A bubble in write-back never writes the register file
  a_no_we_on_bubble: assert property (
    @(posedge clk) disable iff (!rstn) rf_wr.we |-> !wb.bubble
  ) else $error("memwb: register write on a bubble");

endmodule

/* design/riscv_regfile.sv */
module riscv_regfile (
  input  logic                          clk,
  input  logic                          rstn,
  input  riscv_wb_pkg::rf_wr_t          rf_wr,
  input  logic [4:0]                    radr,
  output logic [riscv_wb_pkg::XLEN-1:0] rdata
);

  localparam int NREGS = 32;

  logic [riscv_wb_pkg::XLEN-1:0] regs [NREGS];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // All registers clear on reset
  // Writes to x0 are dropped
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wr.we && rf_wr.dst != 5'd0) begin
      regs[rf_wr.dst] <= rf_wr.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Combinational, x0 hardwired to zero
  assign rdata = (radr == 5'd0) ? '0 : regs[radr];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_top -f src.f -o tb_top \
  && ./obj_dir/tb_top > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q 'All tests passed!' "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

/* src.f */
common/riscv_wb_pkg.sv
design/lsu/riscv_lsu.sv
design/lsu/riscv_load_align.sv
design/riscv_dmem.sv
design/riscv_memwb.sv
design/riscv_regfile.sv
design/riscv_mem_top.sv
bench/tb_checker.sv
bench/tb_top.sv
